//--- alu_core.f
+incdir+common
+incdir+verif
common/alu_pkg.sv
src/alu_shift.sv
src/alu_int.sv
alu_mul/alu_mul.sv
src/alu_top.sv
verif/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the alu testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -f alu_core.f \
  -o alu_sim || exit 1
./obj_dir/alu_sim | tee /dev/stderr | grep -qx "All tests passed" && exit 0 || exit 1

//--- verif/alu_tb_ref.svh
`ifndef ALU_TB_REF_SVH
`define ALU_TB_REF_SVH

function automatic logic is_cmp_op(input alu_op_e op);
  return op inside {SLT, SLTU, BEQ, BNE, BLT, BGE, BLTU, BGEU};
endfunction

function automatic logic is_mul_op(input alu_op_e op);
  return op inside {MUL, MULH, MULHSU, MULHU, MULW};
endfunction

// expected value and compare bit, straight from the isa definitions
function automatic void alu_ref(input alu_op_e op, input logic [`XLEN-1:0] a,
                                input logic [`XLEN-1:0] b, output logic [`XLEN-1:0] res,
                                output logic cmp);
  logic signed [2*`XLEN-1:0] prod;
  logic [31:0]               w;
  res  = '0;
  cmp  = 1'b0;
  prod = '0;
  w    = '0;
  case (op)
    ADD:        res = a + b;
    SUB:        res = a - b;
    AND:        res = a & b;
    OR:         res = a | b;
    XOR:        res = a ^ b;
    SLL:        res = a << b[5:0];
    SRL:        res = a >> b[5:0];
    SRA:        res = $signed(a) >>> b[5:0];
    SLLW:       w = a[31:0] << b[4:0];
    SRLW:       w = a[31:0] >> b[4:0];
    SRAW:       w = $signed(a[31:0]) >>> b[4:0];
    SLT, BLT:   cmp = $signed(a) < $signed(b);
    SLTU, BLTU: cmp = a < b;
    BEQ:        cmp = a == b;
    BNE:        cmp = a != b;
    BGE:        cmp = $signed(a) >= $signed(b);
    BGEU:       cmp = a >= b;
    MUL, MULH, MULW: prod = $signed({{`XLEN{a[`XLEN-1]}}, a}) * $signed({{`XLEN{b[`XLEN-1]}}, b});
    MULHSU:     prod = $signed({{`XLEN{a[`XLEN-1]}}, a}) * $signed({{`XLEN{1'b0}}, b});
    MULHU:      prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
    default:    res = '0;
  endcase
  if (op inside {SLLW, SRLW, SRAW}) res = {{(`XLEN-32){1'b0}}, w};  // upper half zero
  if (op == MUL) res = prod[`XLEN-1:0];
  if (op inside {MULH, MULHSU, MULHU}) res = prod[2*`XLEN-1:`XLEN];
  if (op == MULW) res = {{(`XLEN-32){1'b0}}, prod[31:0]};
  if (is_cmp_op(op)) res = {{(`XLEN-1){1'b0}}, cmp};
endfunction

`endif

//--- verif/alu_tb.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_tb
  import alu_pkg::*;
();

  localparam int N_EDGE     = 3;
  localparam int N_RAND     = 8;
  localparam int N_MUL_RAND = 3;
  localparam int N_MUL      = 5 * (N_EDGE * N_EDGE + N_MUL_RAND) + 4;
  localparam int N_COMB     = 19 * (N_EDGE * N_EDGE + N_RAND + 1) + 8;
  localparam int MAX_CYCLES = N_MUL * (`MUL_ITERS + 4) + N_COMB + 100;

  logic             clk;
  logic             reset;
  alu_req_t         req;
  logic             buff_valid;
  logic [`XLEN-1:0] buff_data;
  logic [`XLEN-1:0] result;
  logic             compare;
  logic             stall_req;
  logic             data_ready;

  // snapshot passed from stimulus to the checker
  event             check_ev;
  string            cur_name;
  alu_req_t         cur_req;
  logic             cur_buff;
  logic [`XLEN-1:0] cur_bdata;
  logic [`XLEN-1:0] act_result;
  logic             act_compare;
  logic             timing_ok;
  logic [`XLEN-1:0] exp_result;
  logic             exp_compare;
  logic             test_ok;
  int               n_tests;
  int               n_fail;
  int               cycle_cnt;
  alu_op_e          op;
  logic [`XLEN-1:0] opa;
  logic [`XLEN-1:0] opb;
  logic [`XLEN-1:0] edge_vals [N_EDGE];

  `include "alu_tb_ref.svh"

  alu_top dut_i (
    .clk          (clk),
    .reset_i      (reset),
    .req_i        (req),
    .buff_valid_i (buff_valid),
    .buff_data_i  (buff_data),
    .result_o     (result),
    .compare_o    (compare),
    .stall_req_o  (stall_req),
    .data_ready_o (data_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [`XLEN-1:0] rand_word();
    return {$urandom(), $urandom()};
  endfunction

  task automatic hand_to_checker(input string name, input logic ok);
    cur_name    = name;
    cur_req     = req;
    cur_buff    = buff_valid;
    cur_bdata   = buff_data;
    act_result  = result;
    act_compare = compare;
    timing_ok   = ok;
    -> check_ev;
  endtask

  // present one op, ride out the stall of a multiply, then sample
  task automatic run_op(input string name, input alu_op_e o, input logic [`XLEN-1:0] a,
                        input logic [`XLEN-1:0] b, input logic buff = 1'b0,
                        input logic [`XLEN-1:0] bdata = '0);
    int   cyc;
    logic ok;
    ok = 1'b1;
    @(posedge clk);
    req        <= '{a, b, o};
    buff_valid <= buff;
    buff_data  <= bdata;
    @(negedge clk);
    if (is_mul_op(o) && !buff) begin
      assert (stall_req) else begin
        $display("%s: stall not raised on the first cycle of the multiply", name);
        ok = 1'b0;
      end
      cyc = 0;
      while (!data_ready && cyc < `MUL_ITERS + 8) begin
        @(negedge clk);
        cyc++;
      end
      // capture edge closes the first cycle, ready MUL_ITERS+1 edges later
      assert (cyc == `MUL_ITERS + 2) else begin
        $display("%s: ready came %0d cycles after the op instead of %0d", name, cyc,
                 `MUL_ITERS + 2);
        ok = 1'b0;
      end
    end else begin
      assert (!data_ready) else begin
        $display("%s: ready pulse without a running multiply", name);
        ok = 1'b0;
      end
    end
    assert (!stall_req) else begin
      $display("%s: stall high on the sampled cycle", name);
      ok = 1'b0;
    end
    hand_to_checker(name, ok);
  endtask

  task automatic replay_during_mul(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    int   cyc;
    logic ok;
    ok = 1'b1;
    @(posedge clk);
    req        <= '{a, b, MULHU};
    buff_valid <= 1'b0;
    repeat (2) @(posedge clk);  // multiplier busy by now
    buff_valid <= 1'b1;
    buff_data  <= rand_word();
    @(negedge clk);
    assert (!stall_req) else begin
      $display("replay_mul: stall stayed high with the buffer valid");
      ok = 1'b0;
    end
    hand_to_checker("replay_mul", ok);
    @(posedge clk);
    req.op     <= ADD;
    buff_valid <= 1'b0;
    @(negedge clk);
    cyc = 0;
    while (!data_ready && cyc < `MUL_ITERS + 8) begin  // drain the abandoned multiply
      @(negedge clk);
      cyc++;
    end
  endtask

  always @(check_ev) begin
    alu_ref(cur_req.op, cur_req.a, cur_req.b, exp_result, exp_compare);
    if (cur_buff && !is_cmp_op(cur_req.op)) exp_result = cur_bdata;  // replayed word
    test_ok = timing_ok;
    assert (act_result === exp_result) else begin
      $display("CHECK FAILED %s result: expected %h, actual %h", cur_name, exp_result,
               act_result);
      test_ok = 1'b0;
    end
    assert (act_compare === exp_compare) else begin
      $display("CHECK FAILED %s compare: expected %b, actual %b", cur_name, exp_compare,
               act_compare);
      test_ok = 1'b0;
    end
    n_tests++;
    if (test_ok) begin
      $display("ok   %s", cur_name);
    end else begin
      $display("FAIL %s", cur_name);
      n_fail++;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt <= MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run still going after %0d clock cycles", MAX_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hb0e365b6));
    reset        = 1'b1;
    req          = '{'0, '0, ADD};
    buff_valid   = 1'b0;
    buff_data    = '0;
    n_tests      = 0;
    n_fail       = 0;
    edge_vals[0] = '0;
    edge_vals[1] = '1;
    edge_vals[2] = {1'b1, {(`XLEN-1){1'b0}}};  // most negative
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    run_op("reset_add", ADD, rand_word(), rand_word());
    for (int o = 0; o <= MULW; o++) begin
      op = alu_op_e'(o);
      for (int i = 0; i < N_EDGE; i++) begin
        for (int j = 0; j < N_EDGE; j++) begin
          run_op($sformatf("%s_edge_%0d%0d", op.name(), i, j), op, edge_vals[i], edge_vals[j]);
        end
      end
      for (int i = 0; i < (is_mul_op(op) ? N_MUL_RAND : N_RAND); i++) begin
        opa = rand_word();
        opb = rand_word();
        if (op inside {SLL, SRL, SRA, SLLW, SRLW, SRAW} && i < 4) begin
          opb[5:0] = (i == 0) ? 6'd0 : (i == 1) ? 6'd63 : (i == 2) ? 6'd32 : 6'd31;
        end
        run_op($sformatf("%s_rand_%0d", op.name(), i), op, opa, opb,
               is_cmp_op(op) && (i % 2 == 1), rand_word());
      end
      if (is_cmp_op(op)) begin
        opa = rand_word();
        run_op($sformatf("%s_equal", op.name()), op, opa, opa);
      end
    end
    run_op("replay_xor", XOR, rand_word(), rand_word(), 1'b1, rand_word());
    replay_during_mul(rand_word(), rand_word());
    run_op("b2b_mul", MUL, rand_word(), rand_word());
    run_op("b2b_mulhsu", MULHSU, rand_word(), rand_word());
    @(posedge clk);
    $display("%0d tests run, %0d failed", n_tests, n_fail);
    if (n_fail == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- src/alu_top.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_top
  import alu_pkg::*;
(
  input  logic             clk,
  input  logic             reset_i,
  input  alu_req_t         req_i,
  input  logic             buff_valid_i,
  input  logic [`XLEN-1:0] buff_data_i,
  output logic [`XLEN-1:0] result_o,
  output logic             compare_o,
  output logic             stall_req_o,
  output logic             data_ready_o
);

  alu_int_res_t       int_res;
  logic               is_mul;
  logic               is_cmp;
  logic               mul_valid;
  logic               mul_ready;
  logic [2*`XLEN-1:0] product;
  logic [`XLEN-1:0]   mul_res;
  logic [`XLEN-1:0]   unit_res;

  assign is_mul = req_i.op inside {MUL, MULH, MULHSU, MULHU, MULW};
  assign is_cmp = req_i.op inside {SLT, SLTU, BEQ, BNE, BLT, BGE, BLTU, BGEU};

  // hold the pipeline until the product is ready, unless a saved result replays
  assign mul_valid   = is_mul & ~mul_ready & ~buff_valid_i;
  assign stall_req_o = mul_valid;

  alu_int u_int (
    .req_i (req_i),
    .res_o (int_res)
  );

  alu_mul u_mul (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .mul_valid_i (mul_valid),
    .mul_ready_o (mul_ready),
    .product_o   (product)
  );

  always_comb begin
    case (req_i.op)
      MUL:                 mul_res = product[`XLEN-1:0];
      MULH, MULHSU, MULHU: mul_res = product[2*`XLEN-1:`XLEN];
      MULW:                mul_res = {{(`XLEN-32){1'b0}}, product[31:0]};  // no sign ext here
      default:             mul_res = '0;
    endcase
  end

  assign unit_res = is_mul ? mul_res : int_res.value;

  // compare bit wins over the replay buffer
  assign result_o = is_cmp       ? {{(`XLEN-1){1'b0}}, int_res.compare} :
                    buff_valid_i ? buff_data_i :
                    unit_res;

  assign compare_o    = int_res.compare;
  assign data_ready_o = mul_ready;

  // product half is picked from the op, so a stalled request must not move
  a_req_held: assert property (@(posedge clk) disable iff (reset_i)
    stall_req_o |=> $stable(req_i));

endmodule

//--- alu_mul/alu_mul.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_mul
  import alu_pkg::*;
(
  input  logic               clk,
  input  logic               reset_i,
  input  alu_req_t           req_i,
  input  logic               mul_valid_i,
  output logic               mul_ready_o,
  output logic [2*`XLEN-1:0] product_o
);

  localparam int CNT_W = $clog2(`MUL_ITERS + 1);

  mul_state_e         state;
  logic [CNT_W-1:0]   iter_cnt;
  logic               cnt_done;
  logic               ready_q;
  logic               a_signed;
  logic               b_signed;
  logic               a_neg;
  logic               b_neg;
  logic [`XLEN-1:0]   a_mag;
  logic [`XLEN-1:0]   b_mag;
  logic [2*`XLEN-1:0] mcand;   // multiplicand, moves left each step
  logic [`XLEN-1:0]   mplier;  // multiplier, moves right each step
  logic [2*`XLEN-1:0] acc;
  logic               neg_q;

  assign a_signed = req_i.op inside {MUL, MULH, MULHSU, MULW};
  assign b_signed = req_i.op inside {MUL, MULH, MULW};

  // operate on magnitudes, fix the sign at the end
  assign a_neg = a_signed & req_i.a[`XLEN-1];
  assign b_neg = b_signed & req_i.b[`XLEN-1];
  assign a_mag = a_neg ? -req_i.a : req_i.a;
  assign b_mag = b_neg ? -req_i.b : req_i.b;

  assign cnt_done = (iter_cnt == CNT_W'(`MUL_ITERS));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state    <= IDLE;
      iter_cnt <= '0;
      ready_q  <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state)
        IDLE: begin
          if (mul_valid_i) begin
            state    <= BUSY;
            iter_cnt <= '0;
          end
        end
        BUSY: begin
          if (cnt_done) begin
            state   <= DONE;
            ready_q <= 1'b1;  // single pulse while in DONE
          end else begin
            iter_cnt <= iter_cnt + 1'b1;
          end
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // shift-add datapath
  always_ff @(posedge clk) begin
    if (state == IDLE && mul_valid_i) begin
      mcand  <= {{`XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      neg_q  <= a_neg ^ b_neg;
    end else if (state == BUSY && !cnt_done) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign mul_ready_o = ready_q;
  assign product_o   = neg_q ? -acc : acc;  // meaningful only in DONE

  a_ready_single: assert property (@(posedge clk) disable iff (reset_i)
    mul_ready_o |=> !mul_ready_o);

  a_ready_in_done: assert property (@(posedge clk) disable iff (reset_i)
    mul_ready_o |-> state == DONE);

  // no early exit from the iteration loop
  a_busy_full: assert property (@(posedge clk) disable iff (reset_i)
    (state == BUSY && !cnt_done) |=> state == BUSY);

endmodule

//--- src/alu_int.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_int
  import alu_pkg::*;
(
  input  alu_req_t     req_i,
  output alu_int_res_t res_o
);

  logic             is_cmp;
  logic             is_sub;
  logic [`XLEN:0]   a_ext;
  logic [`XLEN:0]   b_ext;
  logic [`XLEN:0]   sum;
  logic             carry_top;
  logic             zero_f;
  logic             over_f;
  logic             sign_f;
  logic             carry_f;
  logic             lt_s;
  logic             lt_u;
  logic             eq;
  logic [`XLEN-1:0] shift_res;

  assign is_cmp = req_i.op inside {SLT, SLTU, BEQ, BNE, BLT, BGE, BLTU, BGEU};
  assign is_sub = (req_i.op == SUB) | is_cmp;  // compares go through a - b

  // double sign bit adder
  assign a_ext = {req_i.a[`XLEN-1], req_i.a};
  assign b_ext = {req_i.b[`XLEN-1], req_i.b} ^ {(`XLEN+1){is_sub}};
  assign sum   = a_ext + b_ext + {{`XLEN{1'b0}}, is_sub};

  // carry out of the original msb
  assign carry_top = sum[`XLEN] ^ a_ext[`XLEN] ^ b_ext[`XLEN];

  assign zero_f  = (sum == '0);
  assign over_f  = sum[`XLEN] ^ sum[`XLEN-1];
  assign sign_f  = sum[`XLEN-1];
  assign carry_f = is_sub ^ carry_top;  // borrow when subtracting

  assign lt_s = sign_f ^ over_f;
  assign lt_u = carry_f;
  assign eq   = zero_f;

  alu_shift u_shift (
    .op_i    (req_i.op),
    .data_i  (req_i.a),
    .count_i (req_i.b[5:0]),
    .shift_o (shift_res)
  );

  always_comb begin
    case (req_i.op)
      SLT, BLT:   res_o.compare = lt_s;
      SLTU, BLTU: res_o.compare = lt_u;
      BEQ:        res_o.compare = eq;
      BNE:        res_o.compare = ~eq;
      BGE:        res_o.compare = ~lt_s;
      BGEU:       res_o.compare = ~lt_u;
      default:    res_o.compare = 1'b0;
    endcase
  end

  always_comb begin
    case (req_i.op)
      ADD, SUB: res_o.value = sum[`XLEN-1:0];
      AND:      res_o.value = req_i.a & req_i.b;
      OR:       res_o.value = req_i.a | req_i.b;
      XOR:      res_o.value = req_i.a ^ req_i.b;
      SLL, SRL, SRA, SLLW, SRLW, SRAW: begin
        res_o.value = shift_res;
      end
      default:  res_o.value = '0;  // compares and multiplies resolved in top
    endcase
  end

endmodule

//--- src/alu_shift.sv
`timescale 1ns/100ps
`include "alu_settings.svh"

module alu_shift
  import alu_pkg::*;
(
  input  alu_op_e          op_i,
  input  logic [`XLEN-1:0] data_i,
  input  logic [5:0]       count_i,
  output logic [`XLEN-1:0] shift_o
);

  logic             is_w;
  logic             is_left;
  logic             is_arith;
  logic             fill;
  logic [5:0]       count;
  logic [`XLEN-1:0] operand;
  logic [`XLEN-1:0] stage;
  logic [`XLEN-1:0] result;

  assign is_w     = (op_i == SLLW) || (op_i == SRLW) || (op_i == SRAW);
  assign is_left  = (op_i == SLL) || (op_i == SLLW);
  assign is_arith = (op_i == SRA) || (op_i == SRAW);
  assign fill     = is_arith & (is_w ? data_i[31] : data_i[`XLEN-1]);
  assign count    = is_w ? {1'b0, count_i[4:0]} : count_i;  // word ops drop bit 5

  // left shifts reuse the right shifter through bit reversal
  always_comb begin
    operand = is_w ? {{(`XLEN-32){fill}}, data_i[31:0]} : data_i;
    for (int i = 0; i < `XLEN; i++) begin
      stage[i] = is_left ? operand[`XLEN-1-i] : operand[i];
    end
    for (int k = 0; k < 6; k++) begin
      if (count[k]) begin
        stage = (stage >> (1 << k)) | (fill ? ~({`XLEN{1'b1}} >> (1 << k)) : '0);
      end
    end
    for (int i = 0; i < `XLEN; i++) begin
      result[i] = is_left ? stage[`XLEN-1-i] : stage[i];
    end
  end

  // upper half of word results stays zero, execute stage extends it
  assign shift_o = is_w ? {{(`XLEN-32){1'b0}}, result[31:0]} : result;

endmodule

//--- common/alu_pkg.sv
`include "alu_settings.svh"

package alu_pkg;

  // execute opcodes seen by the alu
  typedef enum logic [4:0] {
    ADD, SUB,           // adder
    AND, OR, XOR,       // logic
    SLL, SRL, SRA,      // 64-bit shifts
    SLLW, SRLW, SRAW,   // word shifts
    SLT, SLTU,          // set less than
    BEQ, BNE,
    BLT, BGE,
    BLTU, BGEU,         // branch compares
    MUL, MULH,
    MULHSU, MULHU,
    MULW                // multiplier ops
  } alu_op_e;

  // multiplier sequencing
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } mul_state_e;

  // operands plus op, fanned out to both units
  typedef struct packed {
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    alu_op_e          op;
  } alu_req_t;

  // combinational unit result
  typedef struct packed {
    logic [`XLEN-1:0] value;
    logic             compare;
  } alu_int_res_t;

endpackage

//--- common/alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// integer datapath width
`define XLEN 64

// one shift-add step per multiplier bit
`define MUL_ITERS `XLEN

`endif
